//--- Bender.yml
package:
  name: proto_port

sources:
  - files:
      - source/uart_pkg.sv
      - source/proto_pkg.sv
      - source/uart_rx.sv
      - source/uart_tx.sv
      - source/reg_mem.sv
      - source/cmd_parser.sv
      - source/proto_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/proto_checker.sv
      - verif/proto_tb.sv

//--- sim.f
source/uart_pkg.sv
source/proto_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/reg_mem.sv
source/cmd_parser.sv
source/proto_top.sv
verif/tb_clock.sv
verif/proto_checker.sv
verif/proto_tb.sv

//--- source/cmd_parser.sv
// Frame parser, decodes write and read commands and sequences the read reply
`timescale 1ns/100ps

module cmd_parser
  import proto_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [7:0]           rx_data,
  input  logic                 rx_valid,
  input  logic [7:0]           mem_rdata,
  output logic [ADDR_BITS-1:0] mem_addr,
  output logic [7:0]           mem_wdata,
  output logic                 mem_we,
  output logic [7:0]           tx_data,
  output logic                 tx_start,
  input  logic                 tx_ready
);

  parse_state_e    state;
  resp_state_e     resp_state;
  cmd_e            cmd;
  logic [3:0]      addr;
  logic [3:0]      data_hi;
  logic [3:0]      data_lo;
  logic [7:0]      rd_byte;    // Byte being replied
  logic            hex_ok;
  logic [3:0]      nib;
  logic            frame_end;  // Valid CR in GET_END

  // ASCII hex digit to {valid, nibble}, either case
  function automatic logic [4:0] hex_to_nib(input logic [7:0] c);
    logic [7:0] d;
    d = 8'h00;
    if (c >= 8'h30 && c <= 8'h39) begin
      d = c - 8'h30;
      return {1'b1, d[3:0]};
    end
    if (c >= 8'h41 && c <= 8'h46) begin
      d = c - 8'h37;  // 'A' -> 10
      return {1'b1, d[3:0]};
    end
    if (c >= 8'h61 && c <= 8'h66) begin
      d = c - 8'h57;  // 'a' -> 10
      return {1'b1, d[3:0]};
    end
    return {1'b0, d[3:0]};
  endfunction

  // Nibble to uppercase ASCII
  function automatic logic [7:0] nib_to_ascii(input logic [3:0] n);
    return (n < 4'd10) ? (8'h30 + {4'h0, n}) : (8'h37 + {4'h0, n});
  endfunction

  assign {hex_ok, nib} = hex_to_nib(rx_data);
  assign frame_end     = rx_valid && state == GET_END && rx_data == CH_END;

  // --------------------
  // Receive FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= IDLE;
      cmd    <= CMD_WRITE;
      mem_we <= 1'b0;
    end else begin
      mem_we <= frame_end && cmd == CMD_WRITE;  // One-cycle pulse
      if (rx_valid) begin
        if (rx_data == CH_START) begin
          state <= GET_CMD;  // Colon restarts from anywhere
        end else begin
          case (state)
            GET_CMD: begin
              if (rx_data == CH_WRITE) begin
                cmd   <= CMD_WRITE;
                state <= GET_ADDR;
              end else if (rx_data == CH_READ) begin
                cmd   <= CMD_READ;
                state <= GET_ADDR;
              end else begin
                state <= IDLE;  // Unknown command
              end
            end
            GET_ADDR: begin
              if (!hex_ok)
                state <= IDLE;
              else
                state <= (cmd == CMD_WRITE) ? GET_HI : GET_END;  // Read has no data
            end
            GET_HI:  state <= hex_ok ? GET_LO : IDLE;
            GET_LO:  state <= hex_ok ? GET_END : IDLE;
            default: state <= IDLE;  // IDLE waits, GET_END always finishes
          endcase
        end
      end
    end
  end

  // Field capture, nibbles kept in place
  always_ff @(posedge clk) begin
    if (rx_valid && hex_ok) begin
      case (state)
        GET_ADDR: addr    <= nib;
        GET_HI:   data_hi <= nib;
        GET_LO:   data_lo <= nib;
        default:  ;
      endcase
    end
  end

  assign mem_addr  = addr;
  assign mem_wdata = {data_hi, data_lo};

  // --------------------
  // Reply sequencer
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_state <= R_IDLE;
    end else if (resp_state == R_IDLE) begin
      if (frame_end && cmd == CMD_READ)
        resp_state <= R_START;  // Reads during a reply are dropped
    end else if (tx_start) begin
      case (resp_state)
        R_START: resp_state <= R_HI;
        R_HI:    resp_state <= R_LO;
        R_LO:    resp_state <= R_END;
        default: resp_state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (resp_state == R_IDLE && frame_end && cmd == CMD_READ)
      rd_byte <= mem_rdata;
  end

  // Transmitter is the only back-pressure
  assign tx_start = tx_ready && resp_state != R_IDLE;

  always_comb begin
    case (resp_state)
      R_HI:    tx_data = nib_to_ascii(rd_byte[7:4]);
      R_LO:    tx_data = nib_to_ascii(rd_byte[3:0]);
      R_END:   tx_data = CH_END;
      default: tx_data = CH_START;
    endcase
  end

endmodule

//--- source/proto_pkg.sv
// Command protocol definitions: frame characters, commands, FSM states, memory size
package proto_pkg;

  // --------------------
  // Frame characters
  // --------------------

  localparam logic [7:0] CH_START = 8'h3A;  // ':'
  localparam logic [7:0] CH_END   = 8'h0D;  // CR
  localparam logic [7:0] CH_WRITE = 8'h31;  // '1'
  localparam logic [7:0] CH_READ  = 8'h32;  // '2'

  // Register memory geometry
  localparam int MEM_DEPTH = 16;
  localparam int ADDR_BITS = 4;

  // --------------------
  // Enums
  // --------------------

  typedef enum logic {
    CMD_WRITE,
    CMD_READ
  } cmd_e;

  // Receive side, one step per received byte
  typedef enum logic [2:0] {
    IDLE,      // Hunting for ':'
    GET_CMD,
    GET_ADDR,
    GET_HI,    // Write only
    GET_LO,    // Write only
    GET_END    // Expect CR
  } parse_state_e;

  // Reply side, one step per sent byte
  typedef enum logic [2:0] {
    R_IDLE,
    R_START,
    R_HI,
    R_LO,
    R_END
  } resp_state_e;

endpackage

//--- source/proto_top.sv
// Serial command port top, UART in and out around the parser and register memory
`timescale 1ns/100ps

module proto_top (
  input  logic       clk,
  input  logic       reset,
  input  logic       rx,
  output logic       tx,
  output logic [3:0] leds
);

  logic [7:0] rx_data;
  logic       rx_valid;
  logic [3:0] mem_addr;
  logic [7:0] mem_wdata;
  logic [7:0] mem_rdata;
  logic       mem_we;
  logic [7:0] tx_data;
  logic       tx_start;
  logic       tx_ready;

  uart_rx rx_i (.clk, .reset, .rx, .rx_data, .rx_valid);

  cmd_parser parser_i (
    .clk, .reset, .rx_data, .rx_valid, .mem_rdata,
    .mem_addr, .mem_wdata, .mem_we, .tx_data, .tx_start, .tx_ready
  );

  reg_mem mem_i (.clk, .reset, .mem_we, .mem_addr, .mem_wdata, .mem_rdata);

  uart_tx tx_i (.clk, .reset, .tx_start, .tx_data, .tx, .tx_ready);

  // Low nibble of every received byte
  always_ff @(posedge clk) begin
    if (reset)
      leds <= '0;
    else if (rx_valid)
      leds <= rx_data[3:0];
  end

endmodule

//--- source/reg_mem.sv
// Register memory, 16 bytes, synchronous write and combinational read
`timescale 1ns/100ps

module reg_mem
  import proto_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 mem_we,
  input  logic [ADDR_BITS-1:0] mem_addr,
  input  logic [7:0]           mem_wdata,
  output logic [7:0]           mem_rdata
);

  logic [7:0] mem [MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < MEM_DEPTH; i++)
        mem[i] <= '0;  // Known contents after reset
    end else if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  assign mem_rdata = mem[mem_addr];  // No read latency

endmodule

//--- source/uart_pkg.sv
// UART line timing, shared by the serial receiver and transmitter
package uart_pkg;

  // --------------------
  // Bit timing
  // --------------------

  // Clock cycles per serial bit, small value for simulation
  // A board build sets this from clock / baud rate
  localparam logic [15:0] CLKS_PER_BIT = 16'd16;

  // Sampling point inside a bit
  localparam logic [15:0] HALF_BIT = CLKS_PER_BIT >> 1;

  // --------------------
  // Frame format
  // --------------------

  localparam int DATA_BITS = 8;  // 8N1, no parity

endpackage

//--- source/uart_rx.sv
// Serial receiver, samples each bit at mid-bit and strobes out one byte per frame
`timescale 1ns/100ps

module uart_rx
  import uart_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 rx,
  output logic [DATA_BITS-1:0] rx_data,
  output logic                 rx_valid
);

  logic                 rx_meta;  // First sync stage
  logic                 rx_s;     // Synchronized line
  logic                 rx_prev;  // For edge detect
  logic                 busy;
  logic [15:0]          cnt;      // Cycles to next sample point
  logic [3:0]           bit_idx;  // 0 start, 1..8 data, 9 stop
  logic [DATA_BITS-1:0] shift;

  // --------------------
  // Input synchronizer
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_meta <= 1'b1;  // Line idles high
      rx_s    <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
      rx_prev <= rx_s;
    end
  end

  // --------------------
  // Bit sequencing
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!busy) begin
        if (rx_prev && !rx_s) begin  // Falling edge, start bit
          busy    <= 1'b1;
          cnt     <= HALF_BIT - 16'd1;
          bit_idx <= '0;
        end
      end else if (cnt != '0) begin
        cnt <= cnt - 16'd1;
      end else begin
        cnt     <= CLKS_PER_BIT - 16'd1;
        bit_idx <= bit_idx + 4'd1;
        if (bit_idx == '0) begin
          busy <= ~rx_s;  // High at mid start bit, a glitch, drop it
        end else if (bit_idx == 4'(DATA_BITS + 1)) begin
          busy     <= 1'b0;
          rx_valid <= rx_s;  // Framing error gives no strobe
        end
      end
    end
  end

  // Data bits arrive LSB first, shift in from the top
  always_ff @(posedge clk) begin
    if (busy && cnt == '0) begin
      if (bit_idx != '0 && bit_idx != 4'(DATA_BITS + 1))
        shift <= {rx_s, shift[DATA_BITS-1:1]};
      if (bit_idx == 4'(DATA_BITS + 1) && rx_s)
        rx_data <= shift;  // Held until next good frame
    end
  end

endmodule

//--- source/uart_tx.sv
// Serial transmitter, sends one 8N1 frame per start strobe and shows a ready level
`timescale 1ns/100ps

module uart_tx
  import uart_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 tx_start,
  input  logic [DATA_BITS-1:0] tx_data,
  output logic                 tx,
  output logic                 tx_ready
);

  logic [DATA_BITS+1:0] frame;    // Stop, data, start; bit 0 is on the line
  logic [15:0]          cnt;      // Cycles left in current bit
  logic [3:0]           bit_cnt;  // Bits already finished

  assign tx = frame[0];

  // --------------------
  // Shift control
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      frame    <= '1;  // Idle line high
      cnt      <= '0;
      bit_cnt  <= '0;
      tx_ready <= 1'b1;
    end else if (tx_ready) begin
      if (tx_start) begin
        frame    <= {1'b1, tx_data, 1'b0};
        cnt      <= CLKS_PER_BIT - 16'd1;
        bit_cnt  <= '0;
        tx_ready <= 1'b0;
      end
    end else if (cnt != '0) begin
      cnt <= cnt - 16'd1;
    end else if (bit_cnt == 4'(DATA_BITS + 1)) begin
      // Stop bit done, frame already shifted back to all ones
      tx_ready <= 1'b1;
    end else begin
      frame   <= {1'b1, frame[DATA_BITS+1:1]};  // Fill with idle level
      cnt     <= CLKS_PER_BIT - 16'd1;
      bit_cnt <= bit_cnt + 4'd1;
    end
  end

endmodule

//--- verif/proto_checker.sv
// Concurrent checks on the parser, memory and transmitter strobes of the port top
`timescale 1ns/100ps

module proto_checker
  import proto_pkg::*;
(
  input logic         clk,
  input logic         reset,
  input logic         rx_valid,
  input logic [7:0]   rx_data,
  input parse_state_e parse_state,
  input logic         mem_we,
  input logic         tx_start,
  input logic         tx_ready,
  input logic         tx
);

  // Write strobe only in the cycle after a CR closes a frame in GET_END
  a_we_after_end: assert property (@(posedge clk) disable iff (reset)
    mem_we |-> $past(rx_valid && parse_state == GET_END && rx_data == CH_END))
    else $error("mem_we pulsed without a closing CR in GET_END");

  // Transmitter takes a start only when ready and goes busy in the next cycle
  a_start_when_ready: assert property (@(posedge clk) disable iff (reset)
    tx_start |-> tx_ready ##1 !tx_ready)
    else $error("tx_start without tx_ready, or tx_ready not dropped after it");

  // Line idles high once reset has been seen for a cycle
  a_tx_idle_in_reset: assert property (@(posedge clk)
    reset && $past(reset) |-> tx)
    else $error("tx line low during reset");

endmodule

bind proto_top proto_checker checker_i (
  .clk, .reset, .rx_valid, .rx_data,
  .parse_state (parser_i.state),
  .mem_we, .tx_start, .tx_ready, .tx
);

//--- verif/proto_patterns.txt
// Kind digit then byte: 1xx byte sent on rx, 2xx expected reply byte on tx,
// 3xx expected LED nibble after the group, followed by an idle gap
13A 131 133 141 135 10D 30D                  // Write A5 to address 3
13A 132 133 10D 30D 23A 241 235 20D          // Read 3, reply A5
13A 132 137 10D 30D 23A 230 230 20D          // Read 7, never written
13A 131 133 147 131 10D 30D                  // Non-hex G in data, dropped
13A 135 133 146 146 10D 30D                  // Unknown command 5, dropped
13A 132 133 10D 30D 23A 241 235 20D          // Address 3 still A5
13A 131 132 13A 131 135 143 133 10D 30D      // Colon restart, write C3 to 5
13A 132 135 10D 30D 23A 243 233 20D          // Read 5, reply C3
13A 131 162 165 137 10D 30D                  // Lowercase write e7 to b
13A 132 142 10D 30D 23A 245 237 20D          // Read B, uppercase reply
15A 137 307                                  // Stray bytes while idle

//--- verif/proto_tb.sv
// Testbench for the serial command port, pattern driven UART stimulus with reply and LED checks
`timescale 1ns/100ps

module proto_tb
  import uart_pkg::*;
();

  localparam int  PAT_MAX   = 256;
  localparam time DRIVE_DLY = 2ns;  // After rising edge

  logic       clk;
  logic       reset;
  logic       rx;
  logic       tx;
  logic [3:0] leds;

  logic [11:0] pat [PAT_MAX];  // Kind nibble, then byte
  logic [7:0]  exp_q [$];      // Expected reply bytes
  logic [7:0]  got_q [$];      // Decoded from tx
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;  // 0 until patterns are loaded

  tb_clock clk_i (.clk);

  proto_top dut_i (.clk, .reset, .rx, .tx, .leds);

  // --------------------
  // Helpers
  // --------------------

  task automatic check_equal(input string name, input logic [7:0] got, input logic [7:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // One 8N1 frame on rx, each bit CLKS_PER_BIT cycles long
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};  // Stop, data, start
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #DRIVE_DLY rx = bits[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  // --------------------
  // tx decoder
  // --------------------

  initial begin : tx_decoder
    logic [7:0] b;
    forever begin
      @(negedge clk);
      if (!reset && tx === 1'b0) begin
        repeat (HALF_BIT) @(negedge clk);  // Middle of start bit
        for (int i = 0; i < DATA_BITS; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          b[i] = tx;  // LSB first
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (tx !== 1'b1) begin
          error_count++;
          $display("Serial decoder saw a low stop bit on tx at %0t", $time);
        end else begin
          got_q.push_back(b);
        end
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, %0d of %0d reply bytes seen",
               cycle_count, got_q.size(), exp_q.size());
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // --------------------
  // Main sequence
  // --------------------

  initial begin : run
    int         n_rec;
    logic [3:0] kind;
    logic [7:0] val;
    reset = 1'b1;
    rx    = 1'b1;  // Idle line
    $readmemh("verif/proto_patterns.txt", pat);
    n_rec = 0;
    while (n_rec < PAT_MAX && !$isunknown(pat[n_rec]))
      n_rec++;
    for (int i = 0; i < n_rec; i++)
      if (pat[i][11:8] == 4'h2)
        exp_q.push_back(pat[i][7:0]);
    cycle_limit = n_rec * 10 * CLKS_PER_BIT * 3;

    repeat (2) @(posedge clk);
    #DRIVE_DLY reset = 1'b0;

    for (int i = 0; i < n_rec; i++) begin
      kind = pat[i][11:8];
      val  = pat[i][7:0];
      case (kind)
        4'h1: send_byte(val);
        4'h3: begin
          repeat (2) @(negedge clk);  // LEDs settle after stop bit strobe
          check_equal("leds", {4'h0, leds}, val);
          repeat (10 * CLKS_PER_BIT) @(posedge clk);  // Gap keeps replies apart
        end
        default: ;  // Reply bytes already queued
      endcase
    end

    // Last reply still leaving, timeout guards this wait
    while (got_q.size() < exp_q.size())
      @(posedge clk);
    repeat (2 * 10 * CLKS_PER_BIT) @(posedge clk);  // Room for a stray extra byte
    if (got_q.size() != exp_q.size()) begin
      error_count++;
      $display("Reply byte count is %0d, expected %0d", got_q.size(), exp_q.size());
    end
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
      check_equal($sformatf("tx byte %0d", i), got_q[i], exp_q[i]);

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- verif/tb_clock.sv
// Testbench clock source, free running with a 20 ns period
`timescale 1ns/100ps

module tb_clock (
  output logic clk
);

  localparam time HALF_PERIOD = 10ns;

  initial clk = 1'b0;

  always #HALF_PERIOD clk = ~clk;  // 50 MHz

endmodule
